//--- hdl/game_pkg.sv
/*
 * Game-side definitions shared by the guess logic:
 *   game state encoding supplied by the top-level game FSM,
 *   person numbering of the nine portrait tiles,
 *   local result of a round,
 *   portrait grid geometry in mouse coordinates
 */

package game_pkg;

    // mouse coordinate width
    localparam int COORD_W = 12;

    // state of the external game FSM
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_PICK   = 2'd1,
        ST_GUESS  = 2'd2,
        ST_REVEAL = 2'd3
    } game_state_t;

    // person number, 0 means none, tiles are 1 to 9 in row-major order
    localparam int PERSON_W = 4;
    typedef logic [PERSON_W-1:0] person_t;

    localparam person_t PERSON_NONE = 4'd0;
    localparam person_t PERSON_MAX  = 4'd9;

    // 2'b11 is never used
    typedef enum logic [1:0] {
        RES_NONE = 2'b00,
        RES_LOSE = 2'b01,
        RES_WIN  = 2'b10
    } result_t;

    // portrait grid, 3 x 3 tiles
    localparam int TILE_COLS = 3;
    localparam int TILE_ROWS = 3;

    // left edges of the tile columns
    localparam logic [COORD_W-1:0] TILE_X0 = 12'd112;
    localparam logic [COORD_W-1:0] TILE_X1 = 12'd312;
    localparam logic [COORD_W-1:0] TILE_X2 = 12'd512;

    // top edges of the tile rows
    localparam logic [COORD_W-1:0] TILE_Y0 = 12'd64;
    localparam logic [COORD_W-1:0] TILE_Y1 = 12'd248;
    localparam logic [COORD_W-1:0] TILE_Y2 = 12'd432;

    // tile size, both edges belong to the tile
    localparam logic [COORD_W-1:0] TILE_W = 12'd160;
    localparam logic [COORD_W-1:0] TILE_H = 12'd144;

endpackage

//--- hdl/link_pkg.sv
/*
 * Pmod cable link definitions:
 *   port width and idle level,
 *   field positions for the right and the left cable side,
 *   result codes on the wire,
 *   person nibble reversal done by the cable
 */

package link_pkg;

    localparam int PMOD_W = 8;

    // unconnected port reads all ones through the pull-ups
    localparam logic [PMOD_W-1:0] PMOD_IDLE = 8'hFF;

    localparam int PERSON_FIELD_W = 4;

    // right side layout
    localparam int R_PERSON_HI = 7;
    localparam int R_PERSON_LO = 4;
    localparam int R_RESULT_HI = 3;
    localparam int R_RESULT_LO = 2;
    localparam int R_RESET     = 1;
    localparam int R_PRESENT   = 0;

    // left side layout
    localparam int L_PERSON_HI = 7;
    localparam int L_PERSON_LO = 4;
    localparam int L_PRESENT   = 3;
    localparam int L_RESET     = 2;
    localparam int L_RESULT_HI = 1;
    localparam int L_RESULT_LO = 0;

    // result code as reported by the sender about itself
    localparam logic [1:0] WIRE_NONE = 2'b00;
    localparam logic [1:0] WIRE_WON  = 2'b01;
    localparam logic [1:0] WIRE_LOST = 2'b10;

    // the cable swaps the person nibble end for end
    function automatic logic [PERSON_FIELD_W-1:0] reverse_nibble(
        input logic [PERSON_FIELD_W-1:0] n
    );
        return {n[0], n[1], n[2], n[3]};
    endfunction

endpackage

//--- hdl/peer_if.sv
/*
 * Decoded peer frame, from the Pmod receiver to the judge
 */

`timescale 1ns/1ps

interface peer_if;

    import game_pkg::*;

    logic    present;
    person_t person;
    result_t result;
    logic    reset_req;

    modport rx (
        output present, person, result, reset_req
    );

    modport judge (
        input present, person, result, reset_req
    );

endinterface

//--- hdl/tile_picker.sv
/*
 * Portrait tile picker
 *   hit test of a right click against the 3 x 3 tile grid,
 *   selected person register, updated only in the guess state
 */

`timescale 1ns/1ps

module tile_picker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rst_sys,
    input  game_pkg::game_state_t        state,
    input  logic [game_pkg::COORD_W-1:0] xpos,
    input  logic [game_pkg::COORD_W-1:0] ypos,
    input  logic                         mouse_right,
    output game_pkg::person_t            selected
);

    import game_pkg::*;

    logic [TILE_COLS-1:0] col_hit;
    logic [TILE_ROWS-1:0] row_hit;
    logic                 hit;
    person_t              hit_person;

    // edges are inclusive on both sides
    assign col_hit[0] = (xpos >= TILE_X0) && (xpos <= TILE_X0 + TILE_W);
    assign col_hit[1] = (xpos >= TILE_X1) && (xpos <= TILE_X1 + TILE_W);
    assign col_hit[2] = (xpos >= TILE_X2) && (xpos <= TILE_X2 + TILE_W);

    assign row_hit[0] = (ypos >= TILE_Y0) && (ypos <= TILE_Y0 + TILE_H);
    assign row_hit[1] = (ypos >= TILE_Y1) && (ypos <= TILE_Y1 + TILE_H);
    assign row_hit[2] = (ypos >= TILE_Y2) && (ypos <= TILE_Y2 + TILE_H);

    // tiles do not overlap, so at most one row/column pair matches
    always_comb begin
        hit        = 1'b0;
        hit_person = PERSON_NONE;
        for (int r = 0; r < TILE_ROWS; r++) begin
            for (int c = 0; c < TILE_COLS; c++) begin
                if (row_hit[r] && col_hit[c]) begin
                    hit        = 1'b1;
                    hit_person = person_t'(r * TILE_COLS + c + 1);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            selected <= PERSON_NONE;
        end else if (rst_sys) begin
            selected <= PERSON_NONE;
        end else if (state == ST_GUESS && mouse_right && hit) begin
            selected <= hit_person;
        end
    end

    selected_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) selected <= PERSON_MAX
    );

endmodule

//--- hdl/link_rx.sv
/*
 * Pmod link receiver
 *   two-flop synchronizers for both cable ports,
 *   connected-side detection with right side priority,
 *   registered decode of the peer frame onto peer_if
 */

`timescale 1ns/1ps

module link_rx (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [link_pkg::PMOD_W-1:0] left_up,
    input  logic [link_pkg::PMOD_W-1:0] right_down,
    peer_if.rx                          peer
);

    import game_pkg::*;
    import link_pkg::*;

    logic [PMOD_W-1:0] left_meta, left_sync;
    logic [PMOD_W-1:0] right_meta, right_sync;

    logic                      right_seen, left_seen;
    logic [PERSON_FIELD_W-1:0] wire_person;
    logic [1:0]                wire_code;
    logic                      wire_reset;
    result_t                   peer_result;

    // synchronizers idle at all ones, which reads as no peer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_meta  <= PMOD_IDLE;
            left_sync  <= PMOD_IDLE;
            right_meta <= PMOD_IDLE;
            right_sync <= PMOD_IDLE;
        end else begin
            left_meta  <= left_up;
            left_sync  <= left_meta;
            right_meta <= right_down;
            right_sync <= right_meta;
        end
    end

    // presence is active low
    assign right_seen = ~right_sync[R_PRESENT];
    assign left_seen  = ~left_sync[L_PRESENT];

    always_comb begin
        if (right_seen) begin
            wire_person = right_sync[R_PERSON_HI:R_PERSON_LO];
            wire_code   = right_sync[R_RESULT_HI:R_RESULT_LO];
            wire_reset  = right_sync[R_RESET];
        end else begin
            wire_person = left_sync[L_PERSON_HI:L_PERSON_LO];
            wire_code   = left_sync[L_RESULT_HI:L_RESULT_LO];
            wire_reset  = left_sync[L_RESET];
        end
        case (wire_code)
            WIRE_WON:  peer_result = RES_WIN;
            WIRE_LOST: peer_result = RES_LOSE;
            default:   peer_result = RES_NONE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            peer.present   <= 1'b0;
            peer.person    <= PERSON_NONE;
            peer.result    <= RES_NONE;
            peer.reset_req <= 1'b0;
        end else if (right_seen || left_seen) begin
            peer.present   <= 1'b1;
            peer.person    <= reverse_nibble(wire_person);
            peer.result    <= peer_result;
            peer.reset_req <= wire_reset;
        end else begin
            peer.present   <= 1'b0;
            peer.person    <= PERSON_NONE;
            peer.result    <= RES_NONE;
            peer.reset_req <= 1'b0;
        end
    end

    present_from_cable: assert property (
        @(posedge clk) disable iff (!rst_n)
        peer.present |-> $past(!right_sync[R_PRESENT] || !left_sync[L_PRESENT])
    );

endmodule

//--- hdl/guess_judge.sv
/*
 * Guess judge
 *   result register with reveal compare and peer-reported outcome,
 *   shared reset request taken from the peer,
 *   formatting of the right and left outgoing Pmod bytes
 */

`timescale 1ns/1ps

module guess_judge (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rst_sys,
    input  game_pkg::game_state_t       state,
    input  game_pkg::person_t           your_person,
    input  game_pkg::person_t           selected,
    peer_if.judge                       peer,
    output game_pkg::result_t           result,
    output logic                        peer_reset,
    output logic [link_pkg::PMOD_W-1:0] right_up,
    output logic [link_pkg::PMOD_W-1:0] left_down
);

    import game_pkg::*;
    import link_pkg::*;

    result_t                   result_nxt;
    logic                      peer_reset_nxt;
    logic [1:0]                own_code;
    logic [PERSON_FIELD_W-1:0] person_wire;

    // own reveal wins over whatever the peer reports
    always_comb begin
        if (state == ST_REVEAL && peer.present) begin
            result_nxt = (selected == peer.person) ? RES_WIN : RES_LOSE;
        end else if (peer.result == RES_WIN) begin
            result_nxt = RES_LOSE;
        end else if (peer.result == RES_LOSE) begin
            result_nxt = RES_WIN;
        end else begin
            result_nxt = result;
        end
    end

    assign peer_reset_nxt = peer.present ? peer.reset_req : peer_reset;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result     <= RES_NONE;
            peer_reset <= 1'b0;
        end else if (rst_sys) begin
            result     <= RES_NONE;
            peer_reset <= 1'b0;
        end else begin
            result     <= result_nxt;
            peer_reset <= peer_reset_nxt;
        end
    end

    // what we report about ourselves
    always_comb begin
        case (result)
            RES_WIN:  own_code = WIRE_WON;
            RES_LOSE: own_code = WIRE_LOST;
            default:  own_code = WIRE_NONE;
        endcase
    end

    // sent reversed, the cable turns it back
    assign person_wire = reverse_nibble(your_person);

    always_comb begin
        right_up                          = PMOD_IDLE;
        right_up[R_PERSON_HI:R_PERSON_LO] = person_wire;
        right_up[R_RESULT_HI:R_RESULT_LO] = own_code;
        right_up[R_RESET]                 = rst_sys;
        right_up[R_PRESENT]               = 1'b0;
    end

    always_comb begin
        left_down                          = PMOD_IDLE;
        left_down[L_PERSON_HI:L_PERSON_LO] = person_wire;
        left_down[L_RESULT_HI:L_RESULT_LO] = own_code;
        left_down[L_RESET]                 = rst_sys;
        left_down[L_PRESENT]               = 1'b0;
    end

    result_encoding_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        result inside {RES_NONE, RES_WIN, RES_LOSE}
    );

endmodule

//--- hdl/guess_link_top.sv
/*
 * Game logic top for the two-board guess game
 *   tile picker, Pmod receiver and judge joined by peer_if
 */

`timescale 1ns/1ps

module guess_link_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rst_sys,
    input  game_pkg::game_state_t        state,
    input  game_pkg::person_t            your_person,
    input  logic [game_pkg::COORD_W-1:0] xpos,
    input  logic [game_pkg::COORD_W-1:0] ypos,
    input  logic                         mouse_right,
    input  logic [link_pkg::PMOD_W-1:0]  left_up,
    input  logic [link_pkg::PMOD_W-1:0]  right_down,
    output logic [link_pkg::PMOD_W-1:0]  right_up,
    output logic [link_pkg::PMOD_W-1:0]  left_down,
    output game_pkg::result_t            result,
    output logic                         peer_reset
);

    game_pkg::person_t selected;

    peer_if peer_bus ();

    tile_picker tile_picker_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rst_sys     (rst_sys),
        .state       (state),
        .xpos        (xpos),
        .ypos        (ypos),
        .mouse_right (mouse_right),
        .selected    (selected)
    );

    link_rx link_rx_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .left_up    (left_up),
        .right_down (right_down),
        .peer       (peer_bus.rx)
    );

    guess_judge guess_judge_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rst_sys     (rst_sys),
        .state       (state),
        .your_person (your_person),
        .selected    (selected),
        .peer        (peer_bus.judge),
        .result      (result),
        .peer_reset  (peer_reset),
        .right_up    (right_up),
        .left_down   (left_down)
    );

endmodule

//--- dv/guess_link_tb.sv
/*
 * Testbench for guess_link_top
 *   peer-board model driving the left or right Pmod port,
 *   reference model of the judge rules and the outgoing bytes,
 *   compare process sampling the outputs after the settling time,
 *   random clicks and peer persons from an xorshift generator
 */

`timescale 1ns/1ps

module guess_link_tb;

    import game_pkg::*;
    import link_pkg::*;

    // port change to result register, 2 sync + decode + judge
    localparam int SETTLE_EDGES = 4;
    localparam int WAIT_LIMIT   = 50;

    logic               clk;
    logic               rst_n;
    logic               rst_sys;
    game_state_t        state;
    person_t            your_person;
    logic [COORD_W-1:0] xpos;
    logic [COORD_W-1:0] ypos;
    logic               mouse_right;
    logic [PMOD_W-1:0]  left_up;
    logic [PMOD_W-1:0]  right_down;
    logic [PMOD_W-1:0]  right_up;
    logic [PMOD_W-1:0]  left_down;
    result_t            result;
    logic               peer_reset;

    // record of the peer frames, index 1 is the right side
    logic    peer_on     [2];
    person_t peer_person [2];
    result_t peer_res    [2];
    logic    peer_req    [2];

    person_t     m_sel;
    result_t     m_result;
    logic        m_peer_reset;
    logic [31:0] rng_state;
    logic        check_req;
    int          edge_count;

    guess_link_top guess_link_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rst_sys     (rst_sys),
        .state       (state),
        .your_person (your_person),
        .xpos        (xpos),
        .ypos        (ypos),
        .mouse_right (mouse_right),
        .left_up     (left_up),
        .right_down  (right_down),
        .right_up    (right_up),
        .left_down   (left_down),
        .result      (result),
        .peer_reset  (peer_reset)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [3:0] flip4(input logic [3:0] n);
        logic [3:0] o;
        for (int i = 0; i < 4; i++) begin
            o[i] = n[3 - i];
        end
        return o;
    endfunction

    function automatic logic [COORD_W-1:0] col_left(input int c);
        return (c == 0) ? TILE_X0 : (c == 1) ? TILE_X1 : TILE_X2;
    endfunction

    function automatic logic [COORD_W-1:0] row_top(input int r);
        return (r == 0) ? TILE_Y0 : (r == 1) ? TILE_Y1 : TILE_Y2;
    endfunction

    // tile under a point, edges included, 0 when outside the grid
    function automatic person_t tile_at(input logic [COORD_W-1:0] x, input logic [COORD_W-1:0] y);
        person_t p;
        p = PERSON_NONE;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                if (x >= col_left(c) && x <= col_left(c) + TILE_W &&
                    y >= row_top(r) && y <= row_top(r) + TILE_H) begin
                    p = person_t'(r * 3 + c + 1);
                end
            end
        end
        return p;
    endfunction

    // one cable byte, same layout for what the peer sends and what we send
    function automatic logic [PMOD_W-1:0] frame_byte(input logic right_side, input person_t p,
                                                     input result_t r, input logic req);
        logic [PMOD_W-1:0] b;
        logic [1:0]        code;
        b    = 8'hFF;
        code = (r == RES_WIN) ? 2'b01 : (r == RES_LOSE) ? 2'b10 : 2'b00;
        if (right_side) begin
            b[R_PERSON_HI:R_PERSON_LO] = flip4(p);
            b[R_RESULT_HI:R_RESULT_LO] = code;
            b[R_RESET]                 = req;
            b[R_PRESENT]               = 1'b0;
        end else begin
            b[L_PERSON_HI:L_PERSON_LO] = flip4(p);
            b[L_RESULT_HI:L_RESULT_LO] = code;
            b[L_RESET]                 = req;
            b[L_PRESENT]               = 1'b0;
        end
        return b;
    endfunction

    // judge rules applied to the settled peer frame, right side first
    function automatic result_t expected_result(input result_t prev);
        int s;
        s = peer_on[1] ? 1 : 0;
        if (rst_sys) begin
            return RES_NONE;
        end
        if (state == ST_REVEAL && peer_on[s]) begin
            return (m_sel == peer_person[s]) ? RES_WIN : RES_LOSE;
        end
        if (peer_on[s] && peer_res[s] == RES_WIN) begin
            return RES_LOSE;
        end
        if (peer_on[s] && peer_res[s] == RES_LOSE) begin
            return RES_WIN;
        end
        return prev;
    endfunction

    function automatic logic expected_reset(input logic prev);
        int s;
        s = peer_on[1] ? 1 : 0;
        if (rst_sys) begin
            return 1'b0;
        end
        return peer_on[s] ? peer_req[s] : prev;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_result(input result_t got, input result_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: result got %s expected %s",
                                     $time, got.name(), exp.name()));
        end
    endtask

    task automatic check_person(input string name, input person_t got, input person_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input logic [PMOD_W-1:0] got,
                              input logic [PMOD_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_outputs();
        m_result     = expected_result(m_result);
        m_peer_reset = expected_reset(m_peer_reset);
        check_result(result, m_result);
        check_bit("peer_reset", peer_reset, m_peer_reset);
        check_person("right_up person", flip4(right_up[R_PERSON_HI:R_PERSON_LO]), your_person);
        check_person("left_down person", flip4(left_down[L_PERSON_HI:L_PERSON_LO]), your_person);
        check_byte("right_up", right_up, frame_byte(1'b1, your_person, m_result, rst_sys));
        check_byte("left_down", left_down, frame_byte(1'b0, your_person, m_result, rst_sys));
    endtask

    // samples mid-cycle once the inputs have had time to reach result
    initial begin : compare_proc
        edge_count = 0;
        forever begin
            @(posedge clk);
            if (check_req) begin
                edge_count++;
                if (edge_count == SETTLE_EDGES) begin
                    @(negedge clk);
                    compare_outputs();
                    edge_count = 0;
                    check_req  = 1'b0;
                end
            end
        end
    end

    task automatic settle();
        int waited;
        waited    = 0;
        check_req = 1'b1;
        while (check_req) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("timeout: the output compare did not finish");
            end
        end
        #1;
    endtask

    task automatic drive_state(input game_state_t st);
        state       = st;
        your_person = person_t'(xorshift32() % 10);
        settle();
    endtask

    task automatic set_sys_reset(input logic v);
        rst_sys = v;
        if (v) begin
            m_sel = PERSON_NONE;
        end
        settle();
    endtask

    // peer board on one side, an absent peer leaves the port at all ones
    task automatic set_peer(input logic right_side, input logic on, input person_t p,
                            input result_t r, input logic req);
        int s;
        s              = right_side ? 1 : 0;
        peer_on[s]     = on;
        peer_person[s] = p;
        peer_res[s]    = r;
        peer_req[s]    = req;
        if (right_side) begin
            right_down = on ? frame_byte(1'b1, p, r, req) : PMOD_IDLE;
        end else begin
            left_up = on ? frame_byte(1'b0, p, r, req) : PMOD_IDLE;
        end
        settle();
    endtask

    // edges, inside points, near misses and anywhere on screen
    task automatic random_click();
        logic [31:0]        r;
        int                 c;
        int                 rw;
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        r  = xorshift32();
        c  = int'(r[3:0]) % 3;
        rw = int'(r[7:4]) % 3;
        x  = col_left(c);
        y  = row_top(rw);
        case (r[9:8])
            2'd0: begin
                x = x + (r[10] ? TILE_W : 12'd0);
                y = y + (r[11] ? TILE_H : 12'd0);
            end
            2'd1: begin
                x = x + 12'(r[19:12] % 160);
                y = y + 12'(r[27:20] % 144);
            end
            2'd2: begin
                x = r[10] ? x - 12'd1 : x + TILE_W + 12'd1;
            end
            default: begin
                x = {2'b00, r[21:12]};
                y = {3'b000, r[30:22]};
            end
        endcase
        xpos        = x;
        ypos        = y;
        mouse_right = 1'b1;
        @(posedge clk);
        #1;
        mouse_right = 1'b0;
        if (state == ST_GUESS && tile_at(x, y) != PERSON_NONE) begin
            m_sel = tile_at(x, y);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin : stimulus
        logic [31:0] r;
        person_t     p;
        int          clicks;
        rst_n        = 1'b0;
        rst_sys      = 1'b0;
        state        = ST_IDLE;
        your_person  = PERSON_NONE;
        xpos         = '0;
        ypos         = '0;
        mouse_right  = 1'b0;
        left_up      = PMOD_IDLE;
        right_down   = PMOD_IDLE;
        check_req    = 1'b0;
        rng_state    = 32'd38;
        m_sel        = PERSON_NONE;
        m_result     = RES_NONE;
        m_peer_reset = 1'b0;
        for (int s = 0; s < 2; s++) begin
            peer_on[s]     = 1'b0;
            peer_person[s] = PERSON_NONE;
            peer_res[s]    = RES_NONE;
            peer_req[s]    = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle after reset, no peer on either side
        drive_state(ST_IDLE);
        set_sys_reset(1'b1);
        set_sys_reset(1'b0);

        // guess rounds against a peer on a random side
        for (int round = 0; round < 16; round++) begin
            random_click();
            drive_state(ST_GUESS);
            clicks = 1 + int'(xorshift32() % 5);
            for (int k = 0; k < clicks; k++) begin
                random_click();
            end
            r = xorshift32();
            if (r[2:1] == 2'd0 && m_sel != PERSON_NONE) begin
                p = m_sel;
            end else begin
                p = person_t'(1 + r[15:8] % 9);
            end
            set_peer(r[0], 1'b1, p, RES_NONE, 1'b0);
            drive_state(ST_REVEAL);
            drive_state(ST_IDLE);
            set_peer(r[0], 1'b0, PERSON_NONE, RES_NONE, 1'b0);
        end

        // outcome reported by the peer outside the reveal
        for (int s = 0; s < 2; s++) begin
            p = person_t'(1 + xorshift32() % 9);
            set_peer(s[0], 1'b1, p, RES_WIN, 1'b0);
            set_peer(s[0], 1'b1, p, RES_LOSE, 1'b0);
            set_peer(s[0], 1'b1, p, RES_NONE, 1'b0);
            set_peer(s[0], 1'b0, PERSON_NONE, RES_NONE, 1'b0);
        end

        // both sides connected, the right frame decides
        set_peer(1'b0, 1'b1, m_sel, RES_WIN, 1'b0);
        p = (m_sel == PERSON_MAX) ? 4'd1 : m_sel + 4'd1;
        set_peer(1'b1, 1'b1, p, RES_LOSE, 1'b0);
        drive_state(ST_REVEAL);
        drive_state(ST_IDLE);
        set_peer(1'b1, 1'b0, PERSON_NONE, RES_NONE, 1'b0);
        set_peer(1'b0, 1'b0, PERSON_NONE, RES_NONE, 1'b0);

        // shared reset in both directions
        p = person_t'(1 + xorshift32() % 9);
        set_peer(1'b1, 1'b1, p, RES_WIN, 1'b1);
        set_sys_reset(1'b1);
        set_sys_reset(1'b0);
        set_peer(1'b1, 1'b1, p, RES_NONE, 1'b0);
        set_peer(1'b1, 1'b0, PERSON_NONE, RES_NONE, 1'b0);
        set_peer(1'b0, 1'b1, p, RES_NONE, 1'b1);
        set_peer(1'b0, 1'b0, PERSON_NONE, RES_NONE, 1'b0);

        $display("No errors");
        $finish;
    end

endmodule

//--- all.f
hdl/game_pkg.sv
hdl/link_pkg.sv
hdl/peer_if.sv
hdl/tile_picker.sv
hdl/link_rx.sv
hdl/guess_judge.sv
hdl/guess_link_top.sv
dv/guess_link_tb.sv

//--- Makefile
TOP := guess_link_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
